// ==== ex_stage.f ====
hdl/ex_pkg.sv
hdl/ex_issue_queue.sv
hdl/ex_alu.sv
hdl/ex_csr_buffer.sv
hdl/ex_mult.sv
hdl/ex_writeback.sv
hdl/ex_stage.sv
verif/ex_checker.sv
verif/tb_ex_stage.sv

// ==== hdl/ex_alu.sv ====
// Integer ALU with branch comparison and resolution, combinational from the dispatch bus
`timescale 1ns/1ps
`default_nettype none

module ex_alu import ex_pkg::*; (
    input  issue_req_t      dispatch_i,
    output fu_result_t      alu_res_o,
    output branch_resolve_t branch_resolve_o
);

    logic [XLEN-1:0] a, b;
    logic [4:0]      shamt;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] alu_data;
    logic            is_branch;
    logic            taken;

    assign a        = dispatch_i.operand_a;
    assign b        = dispatch_i.operand_b;
    assign shamt    = b[4:0];
    assign pc_plus4 = dispatch_i.pc + XLEN'(4);

    // ------------------------------------------------------------
    // Arithmetic and logic
    // ------------------------------------------------------------
    always_comb begin
        case (dispatch_i.op)
            ADD:     alu_data = a + b;
            SUB:     alu_data = a - b;
            AND:     alu_data = a & b;
            OR:      alu_data = a | b;
            XOR:     alu_data = a ^ b;
            SLL:     alu_data = a << shamt;
            SRL:     alu_data = a >> shamt;
            SRA:     alu_data = $unsigned($signed(a) >>> shamt);
            SLT:     alu_data = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU:    alu_data = {{(XLEN-1){1'b0}}, a < b};
            // Branches and JAL write the link address
            default: alu_data = pc_plus4;
        endcase
    end

    // ------------------------------------------------------------
    // Branch comparison
    // ------------------------------------------------------------
    always_comb begin
        case (dispatch_i.op)
            BEQ:     taken = (a == b);
            BNE:     taken = (a != b);
            BLT:     taken = ($signed(a) < $signed(b));
            BGE:     taken = ($signed(a) >= $signed(b));
            BLTU:    taken = (a < b);
            BGEU:    taken = (a >= b);
            JAL:     taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign is_branch = dispatch_i.op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL};

    // Invalid for CSR and multiplier classes, those units answer instead
    assign alu_res_o.valid    = dispatch_i.valid && !is_mult_op(dispatch_i.op) &&
                                (dispatch_i.op != CSRRW);
    assign alu_res_o.trans_id = dispatch_i.trans_id;
    assign alu_res_o.data     = alu_data;

    assign branch_resolve_o.valid      = dispatch_i.valid && is_branch;
    assign branch_resolve_o.taken      = taken;
    assign branch_resolve_o.mispredict = taken != dispatch_i.predict_taken;
    // Offset is signed, wrap-around add gives the right target
    assign branch_resolve_o.target     = taken ? dispatch_i.pc + dispatch_i.operand_c.imm
                                               : pc_plus4;

endmodule

`default_nettype wire

// ==== hdl/ex_csr_buffer.sv ====
// One-entry CSR address buffer, holds the address of a CSRRW until the commit pulse
`timescale 1ns/1ps
`default_nettype none

module ex_csr_buffer import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  issue_req_t               dispatch_i,
    input  logic                     csr_commit_i,
    output fu_result_t               csr_res_o,
    output logic                     csr_busy_o,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    logic                     csr_start;
    logic                     busy_q;
    logic [CSR_ADDR_BITS-1:0] addr_q;

    assign csr_start = dispatch_i.valid && (dispatch_i.op == CSRRW);

    // Old value goes back at once, the write happens on commit
    assign csr_res_o.valid    = csr_start;
    assign csr_res_o.trans_id = dispatch_i.trans_id;
    assign csr_res_o.data     = dispatch_i.operand_a;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q <= 1'b0;
        end else if (csr_start) begin
            busy_q <= 1'b1;
        end else if (csr_commit_i) begin
            busy_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (csr_start) begin
            addr_q <= dispatch_i.operand_c.csr.csr_addr;
        end
    end

    assign csr_busy_o = busy_q;
    assign csr_addr_o = addr_q;

    // Commit only for a buffered CSR op
    a_commit_when_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_commit_i |-> busy_q);

    // Issue side holds a second CSRRW back while the buffer is full
    a_no_csr_overwrite: assert property (@(posedge clk_i) disable iff (!rst_ni)
        csr_start |-> !busy_q);

endmodule

`default_nettype wire

// ==== hdl/ex_issue_queue.sv ====
// Issue side of the execute stage, buffers issued ops and dispatches them without port collisions
`timescale 1ns/1ps
`default_nettype none

module ex_issue_queue import ex_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  issue_req_t issue_i,
    input  logic       csr_busy_i,
    output logic       credit_o,
    output issue_req_t dispatch_o
);

    issue_req_t                mem_q [ISSUE_CREDITS];
    logic [ISSUE_PTR_BITS-1:0] rd_ptr_q, wr_ptr_q;
    logic [ISSUE_CNT_BITS-1:0] count_q;
    // Bit k set: a product reaches the multiplier output k+1 cycles from now
    logic [MULT_STAGES-1:0]    wb_slot_q;
    issue_req_t                disp_q;
    logic                      disp_valid_q;

    issue_req_t cand;
    logic       empty, slot_taken, csr_blocked, go, push, pop;

    function automatic logic [ISSUE_PTR_BITS-1:0] next_ptr(logic [ISSUE_PTR_BITS-1:0] ptr);
        return (ptr == ISSUE_PTR_BITS'(ISSUE_CREDITS - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ------------------------------------------------------------
    // Dispatch decision
    // ------------------------------------------------------------
    always_comb begin
        empty = (count_q == '0);
        // Empty queue forwards the new issue straight to dispatch
        cand  = empty ? issue_i : mem_q[rd_ptr_q];
        // Single-cycle op would meet a product on the write port
        slot_taken  = !is_mult_op(cand.op) && wb_slot_q[0];
        // CSR buffer full now or being filled by the op in dispatch
        csr_blocked = (cand.op == CSRRW) &&
                      (csr_busy_i || (disp_valid_q && disp_q.op == CSRRW));
        go   = cand.valid && !slot_taken && !csr_blocked;
        pop  = go && !empty;
        push = issue_i.valid && !(go && empty);
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q     <= '0;
            wr_ptr_q     <= '0;
            count_q      <= '0;
            wb_slot_q    <= '0;
            disp_valid_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            count_q      <= count_q + ISSUE_CNT_BITS'(push) - ISSUE_CNT_BITS'(pop);
            wb_slot_q    <= {go && is_mult_op(cand.op), wb_slot_q[MULT_STAGES-1:1]};
            disp_valid_q <= go;
        end
    end

    // Entry storage and dispatch payload
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= issue_i;
        end
        if (go) begin
            disp_q <= cand;
        end
    end

    always_comb begin
        dispatch_o       = disp_q;
        dispatch_o.valid = disp_valid_q;
    end

    // One credit comes back per op leaving toward a unit
    assign credit_o = disp_valid_q;

    // Issuer must hold a credit, so the queue never overflows
    a_issue_has_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        issue_i.valid |-> (count_q < ISSUE_CREDITS));

endmodule

`default_nettype wire

// ==== hdl/ex_mult.sv ====
// Two-stage pipelined unsigned multiplier, returns the low or high product word with its tag
`timescale 1ns/1ps
`default_nettype none

module ex_mult import ex_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  issue_req_t dispatch_i,
    output fu_result_t mult_res_o
);

    logic                     mult_start;
    logic                     s1_valid_q, s2_valid_q;
    logic [TRANS_ID_BITS-1:0] s1_id_q, s2_id_q;
    logic [XLEN-1:0]          s1_a_q, s1_b_q;
    logic                     s1_hi_q;
    logic [2*XLEN-1:0]        product;
    logic [XLEN-1:0]          s2_data_q;

    assign mult_start = dispatch_i.valid && is_mult_op(dispatch_i.op);
    assign product    = (2*XLEN)'(s1_a_q) * (2*XLEN)'(s1_b_q);

    // ------------------------------------------------------------
    // Stage valids
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= mult_start;
            s2_valid_q <= s1_valid_q;
        end
    end

    // Stage 1 captures operands, stage 2 the selected half
    always_ff @(posedge clk_i) begin
        s1_a_q    <= dispatch_i.operand_a;
        s1_b_q    <= dispatch_i.operand_b;
        s1_hi_q   <= (dispatch_i.op == MULHU);
        s1_id_q   <= dispatch_i.trans_id;
        s2_data_q <= s1_hi_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
        s2_id_q   <= s1_id_q;
    end

    assign mult_res_o.valid    = s2_valid_q;
    assign mult_res_o.trans_id = s2_id_q;
    assign mult_res_o.data     = s2_data_q;

endmodule

`default_nettype wire

// ==== hdl/ex_pkg.sv ====
// Shared widths, opcodes and bus types of the execute stage, imported by every RTL block
`default_nettype none

package ex_pkg;

    // ------------------------------------------------------------
    // Widths and sizes
    // ------------------------------------------------------------
    localparam int unsigned XLEN           = 32;
    localparam int unsigned TRANS_ID_BITS  = 3;
    localparam int unsigned ISSUE_CREDITS  = 2;
    localparam int unsigned MULT_STAGES    = 2;
    localparam int unsigned CSR_ADDR_BITS  = 12;
    localparam int unsigned ISSUE_PTR_BITS = $clog2(ISSUE_CREDITS);
    localparam int unsigned ISSUE_CNT_BITS = $clog2(ISSUE_CREDITS + 1);

    // ------------------------------------------------------------
    // Opcodes
    // ------------------------------------------------------------
    typedef enum logic [4:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU,
        BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL,
        CSRRW,
        MUL, MULHU
    } fu_op_e;

    // Third operand word, branch offset or CSR address
    typedef union packed {
        logic signed [XLEN-1:0] imm;
        struct packed {
            logic [XLEN-CSR_ADDR_BITS-1:0] pad;
            logic [CSR_ADDR_BITS-1:0]      csr_addr;
        } csr;
    } operand_c_u;

    // ------------------------------------------------------------
    // Buses
    // ------------------------------------------------------------
    typedef struct packed {
        logic                     valid;
        fu_op_e                   op;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        operand_c_u               operand_c;
        logic [XLEN-1:0]          pc;
        logic                     predict_taken;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } issue_req_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          data;
    } fu_result_t;

    typedef struct packed {
        logic            valid;
        logic            taken;
        logic            mispredict;
        logic [XLEN-1:0] target;
    } branch_resolve_t;

    // Multiplier class, the only multi-cycle ops
    function automatic logic is_mult_op(fu_op_e op);
        return op inside {MUL, MULHU};
    endfunction

endpackage

`default_nettype wire

// ==== hdl/ex_stage.sv ====
// Top of the fixed-latency execute stage, connects issue queue, units and write-back port
`timescale 1ns/1ps
`default_nettype none

module ex_stage import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  issue_req_t               issue_i,
    input  logic                     csr_commit_i,
    output logic                     credit_o,
    output fu_result_t               result_o,
    output branch_resolve_t          branch_resolve_o,
    output logic                     csr_pending_o,
    output logic [CSR_ADDR_BITS-1:0] csr_addr_o
);

    issue_req_t dispatch;
    fu_result_t alu_res, csr_res, mult_res;
    logic       csr_busy;

    // ------------------------------------------------------------
    // Issue side
    // ------------------------------------------------------------
    ex_issue_queue i_ex_issue_queue (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .issue_i    (issue_i),
        .csr_busy_i (csr_busy),
        .credit_o   (credit_o),
        .dispatch_o (dispatch)
    );

    // ------------------------------------------------------------
    // Functional units
    // ------------------------------------------------------------
    ex_alu i_ex_alu (
        .dispatch_i       (dispatch),
        .alu_res_o        (alu_res),
        .branch_resolve_o (branch_resolve_o)
    );

    ex_csr_buffer i_ex_csr_buffer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .dispatch_i   (dispatch),
        .csr_commit_i (csr_commit_i),
        .csr_res_o    (csr_res),
        .csr_busy_o   (csr_busy),
        .csr_addr_o   (csr_addr_o)
    );

    ex_mult i_ex_mult (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .dispatch_i (dispatch),
        .mult_res_o (mult_res)
    );

    // Shared write port
    ex_writeback i_ex_writeback (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .alu_res_i  (alu_res),
        .csr_res_i  (csr_res),
        .mult_res_i (mult_res),
        .result_o   (result_o)
    );

    assign csr_pending_o = csr_busy;

endmodule

`default_nettype wire

// ==== hdl/ex_writeback.sv ====
// Shared write port of the execute stage, registers the one unit result of each cycle
`timescale 1ns/1ps
`default_nettype none

module ex_writeback import ex_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  fu_result_t alu_res_i,
    input  fu_result_t csr_res_i,
    input  fu_result_t mult_res_i,
    output fu_result_t result_o
);

    fu_result_t               sel_res;
    logic                     res_valid_q;
    logic [TRANS_ID_BITS-1:0] res_id_q;
    logic [XLEN-1:0]          res_data_q;

    // Slot reservation leaves at most one source active
    always_comb begin
        if (mult_res_i.valid) begin
            sel_res = mult_res_i;
        end else if (csr_res_i.valid) begin
            sel_res = csr_res_i;
        end else begin
            sel_res = alu_res_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= sel_res.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        res_id_q   <= sel_res.trans_id;
        res_data_q <= sel_res.data;
    end

    assign result_o.valid    = res_valid_q;
    assign result_o.trans_id = res_id_q;
    assign result_o.data     = res_data_q;

    // Write-port collisions must have been avoided at issue
    a_one_writer: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_res_i.valid, csr_res_i.valid, mult_res_i.valid}));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the execute stage testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_stage \
    -f ex_stage.f -o sim_ex_stage > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_ex_stage > sim.log 2>&1 || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== verif/ex_checker.sv ====
// Scoreboard of the execute stage testbench that predicts every result by trans_id and compares
`timescale 1ns/1ps
`default_nettype none

module ex_checker import ex_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  issue_req_t               issue_i,
    input  logic                     credit_i,
    input  logic                     csr_commit_i,
    input  fu_result_t               result_i,
    input  branch_resolve_t          branch_resolve_i,
    input  logic                     csr_pending_i,
    input  logic [CSR_ADDR_BITS-1:0] csr_addr_i,
    output int                       errors_o,
    output int                       results_o,
    output int                       credit_pulses_o
);

    typedef struct packed {
        logic [XLEN-1:0] data;
        branch_resolve_t br;
    } expect_t;

    expect_t                  exp_q [8];
    fu_op_e                   op_q [8];
    logic [7:0]               pending_ids = '0;
    branch_resolve_t          br_fifo [$];
    logic [CSR_ADDR_BITS-1:0] csr_fifo [$];
    int                       err_cnt = 0;
    int                       result_cnt = 0;
    int                       credit_cnt = 0;
    int                       issues = 0;
    int                       csr_results = 0;
    int                       commits = 0;
    logic                     pending_prev = 1'b0;

    assign errors_o        = err_cnt;
    assign results_o       = result_cnt;
    assign credit_pulses_o = credit_cnt;

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    function automatic expect_t exp_result(input issue_req_t req);
        expect_t         e;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] link;
        logic [63:0]     prod;
        a      = req.operand_a;
        b      = req.operand_b;
        link   = req.pc + 32'd4;
        prod   = {32'd0, a} * {32'd0, b};
        e      = '0;
        e.data = link;
        case (req.op)
            ADD:     e.data = a + b;
            SUB:     e.data = a - b;
            AND:     e.data = a & b;
            OR:      e.data = a | b;
            XOR:     e.data = a ^ b;
            SLL:     e.data = a << b[4:0];
            SRL:     e.data = a >> b[4:0];
            SRA:     e.data = $signed(a) >>> b[4:0];
            SLT:     e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    e.data = (a < b) ? 32'd1 : 32'd0;
            BEQ:     e.br.taken = (a == b);
            BNE:     e.br.taken = (a != b);
            BLT:     e.br.taken = ($signed(a) < $signed(b));
            BGE:     e.br.taken = ($signed(a) >= $signed(b));
            BLTU:    e.br.taken = (a < b);
            BGEU:    e.br.taken = (a >= b);
            JAL:     e.br.taken = 1'b1;
            CSRRW:   e.data = a;
            MUL:     e.data = prod[31:0];
            MULHU:   e.data = prod[63:32];
            default: ;
        endcase
        // Branch class writes the link address and resolves
        if (req.op inside {BEQ, BNE, BLT, BGE, BLTU, BGEU, JAL}) begin
            e.br.valid      = 1'b1;
            e.br.mispredict = e.br.taken != req.predict_taken;
            e.br.target     = e.br.taken ? req.pc + req.operand_c.imm : link;
        end
        return e;
    endfunction

    // ------------------------------------------------------------
    // Compare
    // ------------------------------------------------------------
    always @(posedge clk_i) begin
        expect_t                  e;
        branch_resolve_t          exp_br;
        logic [CSR_ADDR_BITS-1:0] exp_addr;
        if (!rst_ni) begin
            if (result_i.valid || branch_resolve_i.valid || credit_i || csr_pending_i) begin
                $display("%0t: DUT output active during reset", $time);
                err_cnt++;
            end
        end else begin
            if (result_i.valid) begin
                if (!pending_ids[result_i.trans_id]) begin
                    $display("%0t: result with unknown trans_id %0d", $time, result_i.trans_id);
                    err_cnt++;
                end else begin
                    if (result_i.data !== exp_q[result_i.trans_id].data) begin
                        $display("CHECK FAILED at %0t: result_o.data id %0d expected %h, got %h",
                                 $time, result_i.trans_id, exp_q[result_i.trans_id].data,
                                 result_i.data);
                        err_cnt++;
                    end
                    if (op_q[result_i.trans_id] == CSRRW) begin
                        if (csr_results != commits) begin
                            $display("%0t: CSRRW trans_id %0d returned before the previous commit",
                                     $time, result_i.trans_id);
                            err_cnt++;
                        end
                        csr_results++;
                    end
                    pending_ids[result_i.trans_id] = 1'b0;
                    result_cnt++;
                end
            end
            if (branch_resolve_i.valid) begin
                if (br_fifo.size() == 0) begin
                    $display("%0t: branch resolution with no branch issued", $time);
                    err_cnt++;
                end else begin
                    exp_br = br_fifo.pop_front();
                    if (branch_resolve_i !== exp_br) begin
                        $display("CHECK FAILED at %0t: branch_resolve_o expected %h, got %h",
                                 $time, exp_br, branch_resolve_i);
                        err_cnt++;
                    end
                end
            end
            if (issue_i.valid) begin
                e                             = exp_result(issue_i);
                exp_q[issue_i.trans_id]       = e;
                op_q[issue_i.trans_id]        = issue_i.op;
                pending_ids[issue_i.trans_id] = 1'b1;
                issues++;
                if (e.br.valid) begin
                    br_fifo.push_back(e.br);
                end
                if (issue_i.op == CSRRW) begin
                    csr_fifo.push_back(issue_i.operand_c.csr.csr_addr);
                end
            end
            if (credit_i) begin
                credit_cnt++;
                if (credit_cnt > issues) begin
                    $display("%0t: extra credit returned with nothing issued", $time);
                    err_cnt++;
                end
            end
            if (csr_commit_i) begin
                commits++;
            end
            if (csr_pending_i && !pending_prev) begin
                if (csr_fifo.size() == 0) begin
                    $display("%0t: csr_pending_o rose with no CSRRW issued", $time);
                    err_cnt++;
                end else begin
                    exp_addr = csr_fifo.pop_front();
                    if (csr_addr_i !== exp_addr) begin
                        $display("CHECK FAILED at %0t: csr_addr_o expected %h, got %h",
                                 $time, exp_addr, csr_addr_i);
                        err_cnt++;
                    end
                end
            end
        end
        pending_prev = csr_pending_i;
    end

endmodule

`default_nettype wire

// ==== verif/tb_ex_stage.sv ====
// Testbench top for the execute stage, drives random credit-limited issues and prints the verdict
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage import ex_pkg::*; ();

    localparam int N_ALU       = 40;
    localparam int N_BR        = 30;
    localparam int N_MUL       = 30;
    localparam int N_CSR       = 16;
    localparam int N_MIX       = 40;
    localparam int N_TOTAL     = N_ALU + N_BR + N_MUL + N_CSR + N_MIX;
    localparam int CYCLE_LIMIT = 20 * N_TOTAL + 200;
    localparam int DRAIN_LIMIT = 100;

    logic                     clk;
    logic                     rst_n;
    issue_req_t               issue;
    logic                     csr_commit;
    logic                     credit;
    fu_result_t               result;
    branch_resolve_t          branch_res;
    logic                     csr_pending;
    logic [CSR_ADDR_BITS-1:0] csr_addr;

    int                       seed = 32'h4e91_2439;
    int                       credits;
    logic [7:0]               id_busy;
    logic [TRANS_ID_BITS-1:0] next_id;
    int                       issue_cnt;
    int                       tb_errors;
    int                       pend_wait;
    int                       chk_errors;
    int                       chk_results;
    int                       credit_pulses;

    ex_stage UUT (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .issue_i          (issue),
        .csr_commit_i     (csr_commit),
        .credit_o         (credit),
        .result_o         (result),
        .branch_resolve_o (branch_res),
        .csr_pending_o    (csr_pending),
        .csr_addr_o       (csr_addr)
    );

    ex_checker i_ex_checker (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .issue_i          (issue),
        .credit_i         (credit),
        .csr_commit_i     (csr_commit),
        .result_i         (result),
        .branch_resolve_i (branch_res),
        .csr_pending_i    (csr_pending),
        .csr_addr_i       (csr_addr),
        .errors_o         (chk_errors),
        .results_o        (chk_results),
        .credit_pulses_o  (credit_pulses)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Issuer
    // ------------------------------------------------------------
    function automatic fu_op_e pick_op(input int kind, input logic [31:0] r);
        case (kind)
            0:       return fu_op_e'(5'(r % 10));
            1:       return fu_op_e'(5'(BEQ) + 5'(r % 7));
            2:       return r[8] ? (r[0] ? MULHU : MUL) : fu_op_e'(5'(r % 10));
            3:       return r[8] ? CSRRW : fu_op_e'(5'(r % 10));
            default: return fu_op_e'(5'(r % 20));
        endcase
    endfunction

    function automatic logic drained();
        return (credits == ISSUE_CREDITS) && (id_busy == '0) && !csr_pending;
    endfunction

    // One clock: collect credits and results, drop valid, commit CSRs
    task automatic clock_step();
        @(posedge clk);
        if (credit) begin
            credits++;
        end
        if (result.valid) begin
            id_busy[result.trans_id] = 1'b0;
        end
        if (credits > ISSUE_CREDITS) begin
            $display("%0t: issuer holds %0d credits, more than %0d", $time, credits,
                     ISSUE_CREDITS);
            tb_errors++;
        end
        issue.valid <= 1'b0;
        // Commit a CSR op a few cycles after the buffer fills
        if (csr_pending && !csr_commit) begin
            if (pend_wait == 3) begin
                csr_commit <= 1'b1;
                pend_wait = 0;
            end else begin
                pend_wait++;
            end
        end else begin
            csr_commit <= 1'b0;
        end
    endtask

    task automatic issue_one(input int kind);
        logic [31:0] r;
        logic [31:0] pc_rnd;
        issue_req_t  req;
        clock_step();
        while (credits == 0 || id_busy[next_id]) begin
            clock_step();
        end
        r                 = $random(seed);
        pc_rnd            = $random(seed);
        req.valid         = 1'b1;
        req.op            = pick_op(kind, r);
        req.operand_a     = $random(seed);
        // Equal operands now and then, so equality branches are taken
        req.operand_b     = r[31] ? req.operand_a : $random(seed);
        req.operand_c.imm = {{19{r[20]}}, r[20:9], 1'b0};
        req.pc            = {pc_rnd[31:2], 2'b00};
        req.predict_taken = r[30];
        req.trans_id      = next_id;
        issue <= req;
        credits--;
        id_busy[next_id] = 1'b1;
        next_id++;
        issue_cnt++;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!drained() && waited < DRAIN_LIMIT) begin
            clock_step();
            waited++;
        end
        if (!drained()) begin
            $display("%0t: results missing for trans_ids %b after %0d cycles", $time,
                     id_busy, DRAIN_LIMIT);
            tb_errors++;
        end
    endtask

    task automatic run_test(input int num, input string name, input int count, input int kind);
        int errors_before;
        errors_before = tb_errors + chk_errors;
        for (int i = 0; i < count; i++) begin
            issue_one(kind);
        end
        wait_drain();
        $display("Test %0d %s: %0d issued, %0d errors", num, name, count,
                 tb_errors + chk_errors - errors_before);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        issue      = '0;
        csr_commit = 1'b0;
        rst_n      = 1'b0;
        credits    = ISSUE_CREDITS;
        id_busy    = '0;
        next_id    = '0;
        issue_cnt  = 0;
        tb_errors  = 0;
        pend_wait  = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        run_test(1, "ALU ops", N_ALU, 0);
        run_test(2, "branches and JAL", N_BR, 1);
        run_test(3, "multiplies mixed with ALU ops", N_MUL, 2);
        run_test(4, "CSRRW with commit", N_CSR, 3);
        run_test(5, "random mix and credit return", N_MIX, 4);
        if (credit_pulses != issue_cnt) begin
            $display("Credit pulses %0d do not match issues %0d", credit_pulses, issue_cnt);
            tb_errors++;
        end
        $display("Tests: 5, issues: %0d, results: %0d, credit pulses: %0d, errors: %0d",
                 issue_cnt, chk_results, credit_pulses, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run stopped after %0d cycles", CYCLE_LIMIT);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
